// ==== uop_core.f ====
+incdir+logic
logic/uop_pkg.sv
logic/mem_bus_if.sv
logic/multi_op_sequencer.sv
logic/micro_exec.sv
logic/mem_arbiter.sv
logic/data_ram.sv
logic/uop_core.sv
verif/uop_core_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = uop_core_tb
FILELIST  = uop_core.f
BUILD     = obj_dir
SIM       = $(BUILD)/V$(TOP)
HEADERS   = logic/uop_cfg.svh
SOURCES   = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; \
	echo "$$out" | grep -q '^RESULT: PASS$$'

clean:
	rm -rf $(BUILD)

// ==== verif/uop_core_tb.sv ====
`timescale 1ns/1ns
`include "uop_cfg.svh"

module uop_core_tb;

localparam int KIND_INSTR = 0;
localparam int KIND_BUSY  = 1;     // Instruction with host reads alongside.
localparam int KIND_WRITE = 2;
localparam int KIND_READ  = 3;
localparam int PROBE      = 255;   // Word that single STRs via r0 land in.

typedef struct {
        int             kind;
        int             test;
        logic [31:0]    word;
        int             addr;
} entry_t;

logic                   i_clk;
logic                   i_reset;
logic [31:0]            i_instr;
logic                   i_instr_valid;
logic                   o_instr_ready;
logic                   i_host_req;
logic                   i_host_we;
logic [`UOP_ADDR_W-1:0] i_host_addr;
logic [31:0]            i_host_wdata;
logic [31:0]            o_host_rdata;
logic                   o_host_ack;

entry_t         table_q[$];
logic [31:0]    mregs [16];     // Architectural register model.
logic [31:0]    mmem [256];     // Memory model, in words.
int             errors;
int             checks;
int             test_errors;
int             tests;
bit             build_done;
string          test_names [6] = '{"mov_str", "stm_modes", "ldm_stm_copy", "swap",
                                   "empty_list", "host_during_block"};

uop_core UUT (
        .i_clk          (i_clk),
        .i_reset        (i_reset),
        .i_instr        (i_instr),
        .i_instr_valid  (i_instr_valid),
        .o_instr_ready  (o_instr_ready),
        .i_host_req     (i_host_req),
        .i_host_we      (i_host_we),
        .i_host_addr    (i_host_addr),
        .i_host_wdata   (i_host_wdata),
        .o_host_rdata   (o_host_rdata),
        .o_host_ack     (o_host_ack)
);

always #2 i_clk = ~i_clk;

function automatic logic [31:0] enc_mov(input int rd, input logic [7:0] imm, input int rot);
        return 32'hE3A0_0000 | (32'(rd) << 12) | (32'(rot) << 8) | {24'd0, imm};
endfunction

function automatic logic [31:0] enc_str(input int rd, input int rn, input int off);
        return 32'hE580_0000 | (32'(rn) << 16) | (32'(rd) << 12) | 32'(off);
endfunction

function automatic logic [31:0] enc_block(input bit p, input bit u, input bit w, input bit l,
                                          input int rn, input logic [15:0] list);
        return 32'hE800_0000 | (32'(p) << 24) | (32'(u) << 23) | (32'(w) << 21) |
               (32'(l) << 20) | (32'(rn) << 16) | {16'd0, list};
endfunction

function automatic logic [31:0] enc_swp(input int rd, input int rm, input int rn);
        return 32'hE100_0090 | (32'(rn) << 16) | (32'(rd) << 12) | 32'(rm);
endfunction

function automatic int count_bits(input logic [15:0] list);
        int n;
        n = 0;
        for (int i = 0; i < 16; i++)
                n += int'(list[i]);
        return n;
endfunction

function automatic logic [31:0] ror32(input logic [31:0] v, input int sh);
        if (sh == 0)
                return v;
        return (v >> sh) | (v << (32 - sh));
endfunction

// ARM semantics of the supported subset, applied to the models.
function automatic void execute_model(input logic [31:0] w);
        logic [31:0]    base;
        logic [31:0]    addr;
        logic [31:0]    off;
        logic [31:0]    tmp;
        logic [31:0]    span;
        base = mregs[w[19:16]];
        if (w[27:25] == 3'b100)
        begin
                span = 32'(4 * count_bits(w[15:0]));
                if (w[23])
                        addr = w[24] ? base + 4 : base;
                else
                        addr = w[24] ? base - span : base - span + 4;
                for (int i = 0; i < 16; i++)
                begin
                        if (w[i])
                        begin
                                if (w[20])
                                        mregs[i] = mmem[addr[9:2]];
                                else
                                        mmem[addr[9:2]] = mregs[i];
                                addr += 4;
                        end
                end
                if (w[21])
                        mregs[w[19:16]] = w[23] ? base + span : base - span;
        end
        else if (w[27:20] == 8'h10 && w[11:4] == 8'h09)
        begin
                tmp = mmem[base[9:2]];
                mmem[base[9:2]] = mregs[w[3:0]];
                mregs[w[15:12]] = tmp;
        end
        else if (w[27:21] == 7'b0011101)
                mregs[w[15:12]] = ror32({24'd0, w[7:0]}, 2 * int'(w[11:8]));
        else if (w[27:25] == 3'b010)
        begin
                off  = w[23] ? {20'd0, w[11:0]} : -{20'd0, w[11:0]};
                addr = w[24] ? base + off : base;
                if (w[20])
                        mregs[w[15:12]] = mmem[addr[9:2]];
                else
                        mmem[addr[9:2]] = mregs[w[15:12]];
                if (w[21] || !w[24])
                        mregs[w[19:16]] = base + off;
        end
endfunction

task automatic add_entry(input int kind, input int test, input logic [31:0] word,
                         input int addr);
        entry_t e;
        e.kind = kind;
        e.test = test;
        e.word = word;
        e.addr = addr;
        table_q.push_back(e);
endtask

task automatic build_table();
        int     base;
        int     start;
        bit     p;
        bit     u;
        // Store and readback of moved values.
        add_entry(KIND_INSTR, 0, enc_mov(1, 8'h5a, 0), 0);
        add_entry(KIND_INSTR, 0, enc_mov(2, 8'h40, 0), 0);
        add_entry(KIND_INSTR, 0, enc_mov(3, 8'($urandom), 0), 0);
        add_entry(KIND_INSTR, 0, enc_str(1, 2, 0), 0);
        add_entry(KIND_INSTR, 0, enc_str(3, 2, 4), 0);
        add_entry(KIND_READ, 0, 0, 16);
        add_entry(KIND_READ, 0, 0, 17);
        for (int idx = 0; idx < 8; idx++)
        begin
                p    = (idx / 2) % 2 == 1;      // IA, IB, DA, DB order.
                u    = idx < 4;
                base = 32 + idx * 16;
                start = u ? (p ? base + 4 : base) : (p ? base - 16 : base - 12);
                // Fresh data for each mode.
                for (int r = 1; r <= 4; r++)
                        add_entry(KIND_INSTR, 1, enc_mov(r, 8'($urandom), 0), 0);
                add_entry(KIND_INSTR, 1, enc_mov(5, 8'(base), 0), 0);
                add_entry(KIND_INSTR, 1, enc_block(p, u, idx % 2 == 1, 1'b0, 5, 16'h001e), 0);
                for (int k = 0; k < 4; k++)
                        add_entry(KIND_READ, 1, 0, start / 4 + k);
                add_entry(KIND_INSTR, 1, enc_str(5, 0, 12'h3fc), 0);
                add_entry(KIND_READ, 1, 0, PROBE);
        end
        for (int k = 0; k < 6; k++)
                add_entry(KIND_WRITE, 2, $urandom, 44 + k);
        add_entry(KIND_INSTR, 2, enc_mov(6, 8'hb0, 0), 0);
        add_entry(KIND_INSTR, 2, enc_mov(8, 8'hd0, 0), 0);
        add_entry(KIND_INSTR, 2, enc_block(1'b0, 1'b1, 1'b0, 1'b1, 6, 16'h00be), 0);
        add_entry(KIND_INSTR, 2, enc_block(1'b0, 1'b1, 1'b0, 1'b0, 8, 16'h00be), 0);
        for (int k = 0; k < 6; k++)
                add_entry(KIND_READ, 2, 0, 52 + k);
        add_entry(KIND_WRITE, 3, $urandom, 60);
        add_entry(KIND_INSTR, 3, enc_mov(9, 8'hf0, 0), 0);
        add_entry(KIND_INSTR, 3, enc_mov(10, 8'($urandom), 0), 0);
        add_entry(KIND_INSTR, 3, enc_swp(11, 10, 9), 0);
        add_entry(KIND_INSTR, 3, enc_str(11, 0, 12'h3fc), 0);
        add_entry(KIND_READ, 3, 0, 60);
        add_entry(KIND_READ, 3, 0, PROBE);
        add_entry(KIND_INSTR, 4, enc_mov(12, 8'h44, 0), 0);
        for (int m = 0; m < 4; m++)
        begin
                add_entry(KIND_INSTR, 4, enc_block(m % 2 == 1, m < 2, 1'b1, m == 0, 12, 16'h0), 0);
                add_entry(KIND_INSTR, 4, enc_str(12, 0, 12'h3fc), 0);
                add_entry(KIND_READ, 4, 0, PROBE);
        end
        for (int k = 0; k < 16; k++)
                add_entry(KIND_WRITE, 5, $urandom, 64 + k);
        add_entry(KIND_INSTR, 5, enc_mov(13, 8'h40, 15), 0);   // 0x100
        add_entry(KIND_INSTR, 5, enc_mov(14, 8'h50, 15), 0);   // 0x140
        add_entry(KIND_BUSY, 5, enc_block(1'b0, 1'b1, 1'b0, 1'b1, 13, 16'h1ffe), 0);
        add_entry(KIND_BUSY, 5, enc_block(1'b0, 1'b1, 1'b0, 1'b0, 14, 16'h1ffe), 0);
        for (int k = 0; k < 12; k++)
                add_entry(KIND_READ, 5, 0, 80 + k);
endtask

task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] got);
        checks++;
        assert (got === exp)
        else
        begin
                $display("Mismatch at %0t ns: %s expected %08h got %08h", $time, name, exp, got);
                errors++;
                test_errors++;
        end
endtask

// Instruction is held until a cycle where ready is high.
task automatic issue_instr(input logic [31:0] w);
        @(posedge i_clk);
        #1;
        i_instr       = w;
        i_instr_valid = 1'b1;
        do
                @(negedge i_clk);
        while (!o_instr_ready);
        @(posedge i_clk);
        #1 i_instr_valid = 1'b0;
endtask

task automatic host_access(input logic we, input int addr, input logic [31:0] wdata,
                           output logic [31:0] rdata);
        @(posedge i_clk);
        #1;
        i_host_req   = 1'b1;
        i_host_we    = we;
        i_host_addr  = `UOP_ADDR_W'(addr);
        i_host_wdata = wdata;
        do
                @(negedge i_clk);
        while (!o_host_ack);
        rdata = o_host_rdata;       // Valid with ack.
        @(posedge i_clk);
        #1;
        i_host_req = 1'b0;
        i_host_we  = 1'b0;
endtask

task automatic read_and_check(input int addr);
        logic [31:0] got;
        repeat ($urandom % 8) @(posedge i_clk);
        host_access(1'b0, addr, 32'd0, got);
        check_value($sformatf("o_host_rdata word %0d", addr), mmem[addr], got);
endtask

// Source area of the long transfer, untouched by the STM.
task automatic background_reads();
        repeat (4)
                read_and_check(64 + int'($urandom % 16));
endtask

task automatic apply_entry(input entry_t e);
        logic [31:0] unused;
        case (e.kind)
        KIND_INSTR:
        begin
                issue_instr(e.word);
                execute_model(e.word);
        end
        KIND_BUSY:
        begin
                fork
                        issue_instr(e.word);
                        background_reads();
                join
                execute_model(e.word);
        end
        KIND_WRITE:
        begin
                host_access(1'b1, e.addr, e.word, unused);
                mmem[e.addr] = e.word;
        end
        default:
                read_and_check(e.addr);
        endcase
endtask

task automatic report_test(input int id);
        tests++;
        if (test_errors == 0)
                $display("Test %0d %s: ok", id, test_names[id]);
        else
                $display("Test %0d %s: failed with %0d errors", id, test_names[id], test_errors);
        test_errors = 0;
endtask

initial
begin
        void'($urandom(32'hcdbf_4bf7));
        i_clk         = 1'b0;
        i_reset       = 1'b1;
        i_instr       = '0;
        i_instr_valid = 1'b0;
        i_host_req    = 1'b0;
        i_host_we     = 1'b0;
        i_host_addr   = '0;
        i_host_wdata  = '0;
        for (int i = 0; i < 16; i++)
                mregs[i] = '0;
        build_table();
        build_done = 1'b1;
        repeat (16) @(posedge i_clk);
        #1 i_reset = 1'b0;
        // Idle core accepts instructions and the host sees no ack.
        check_value("o_instr_ready", 32'd1, {31'd0, o_instr_ready});
        check_value("o_host_ack", 32'd0, {31'd0, o_host_ack});
        begin
                int cur;
                cur = table_q[0].test;
                foreach (table_q[i])
                begin
                        if (table_q[i].test != cur)
                        begin
                                report_test(cur);
                                cur = table_q[i].test;
                        end
                        apply_entry(table_q[i]);
                end
                report_test(cur);
        end
        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0)
                $display("RESULT: PASS");
        else
                $display("RESULT: FAIL");
        $finish;
end

// Budget of 200 cycles per table entry.
initial
begin
        wait (build_done);
        repeat (16 + 200 * table_q.size()) @(posedge i_clk);
        $display("Timeout: the table did not finish within its cycle budget");
        $display("RESULT: FAIL");
        $finish;
end

endmodule

// ==== logic/uop_core.sv ====
`timescale 1ns/1ns
`include "uop_cfg.svh"

module uop_core (
        input  logic                    i_clk,
        input  logic                    i_reset,
        input  logic [31:0]             i_instr,
        input  logic                    i_instr_valid,
        output logic                    o_instr_ready,
        input  logic                    i_host_req,
        input  logic                    i_host_we,
        input  logic [`UOP_ADDR_W-1:0]  i_host_addr,
        input  logic [31:0]             i_host_wdata,
        output logic [31:0]             o_host_rdata,
        output logic                    o_host_ack
);

uop_pkg::uop_t  uop;
logic           uop_valid;
logic           seq_stall;
logic           exec_busy;

mem_bus_if exec_bus ();
mem_bus_if host_bus ();
mem_bus_if ram_bus ();

assign host_bus.req   = i_host_req;
assign host_bus.we    = i_host_we;
assign host_bus.addr  = i_host_addr;
assign host_bus.wdata = i_host_wdata;
assign o_host_rdata   = host_bus.rdata;
assign o_host_ack     = host_bus.ack;

assign o_instr_ready = !(seq_stall || exec_busy);

multi_op_sequencer u_seq (
        .i_clk          (i_clk),
        .i_reset        (i_reset),
        .i_instr        (i_instr),
        .i_instr_valid  (i_instr_valid),
        .i_exec_busy    (exec_busy),
        .o_uop          (uop),
        .o_uop_valid    (uop_valid),
        .o_stall        (seq_stall)
);

micro_exec u_exec (
        .i_clk          (i_clk),
        .i_reset        (i_reset),
        .i_uop          (uop),
        .i_uop_valid    (uop_valid),
        .o_busy         (exec_busy),
        .bus            (exec_bus.requester)
);

mem_arbiter u_arb (
        .i_clk          (i_clk),
        .i_reset        (i_reset),
        .exec_bus       (exec_bus.responder),
        .host_bus       (host_bus.responder),
        .ram_bus        (ram_bus.requester)
);

data_ram u_ram (
        .i_clk          (i_clk),
        .bus            (ram_bus.responder)
);

endmodule

// ==== logic/data_ram.sv ====
`timescale 1ns/1ns
`include "uop_cfg.svh"

module data_ram (
        input  logic            i_clk,
        mem_bus_if.responder    bus
);

logic [31:0]    mem [`UOP_RAM_DEPTH];
logic           ack_q;
logic [31:0]    rdata_q;
logic           take;

// A request held through its ack cycle is not served twice.
assign take = bus.req && !ack_q;

always_ff @(posedge i_clk)
begin
        ack_q <= take;
        if (take)
        begin
                if (bus.we)
                        mem[bus.addr] <= bus.wdata;
                rdata_q <= mem[bus.addr];
        end
end

assign bus.ack   = ack_q;
assign bus.rdata = rdata_q;

endmodule

// ==== logic/mem_arbiter.sv ====
`timescale 1ns/1ns
`include "uop_cfg.svh"

module mem_arbiter (
        input  logic            i_clk,
        input  logic            i_reset,
        mem_bus_if.responder    exec_bus,
        mem_bus_if.responder    host_bus,
        mem_bus_if.requester    ram_bus
);

logic                   active_q;       // Transfer in flight.
logic                   gnt_host_q;     // Current or last winner.
logic                   pick_host;
logic [`UOP_ADDR_W-1:0] sel_addr;

// Last winner loses a tie.
always_comb
begin
        if (exec_bus.req && host_bus.req)
                pick_host = !gnt_host_q;
        else
                pick_host = host_bus.req;
end

always_ff @(posedge i_clk)
begin
        if (i_reset)
        begin
                active_q   <= 1'b0;
                gnt_host_q <= 1'b0;
        end
        else if (!active_q)
        begin
                if (exec_bus.req || host_bus.req)
                begin
                        active_q   <= 1'b1;
                        gnt_host_q <= pick_host;
                end
        end
        else if (ram_bus.ack)
                active_q <= 1'b0;
end

assign sel_addr      = gnt_host_q ? host_bus.addr : exec_bus.addr;
assign ram_bus.req   = active_q;
assign ram_bus.we    = gnt_host_q ? host_bus.we : exec_bus.we;
assign ram_bus.addr  = sel_addr;
assign ram_bus.wdata = gnt_host_q ? host_bus.wdata : exec_bus.wdata;

assign exec_bus.ack   = ram_bus.ack && active_q && !gnt_host_q;
assign host_bus.ack   = ram_bus.ack && active_q && gnt_host_q;
assign exec_bus.rdata = gnt_host_q ? '0 : ram_bus.rdata;
assign host_bus.rdata = gnt_host_q ? ram_bus.rdata : '0;

// Each ack answers a request still held by that peer.
a_exec_ack: assert property (@(posedge i_clk) disable iff (i_reset)
        exec_bus.ack |-> exec_bus.req);
a_host_ack: assert property (@(posedge i_clk) disable iff (i_reset)
        host_bus.ack |-> host_bus.req);

endmodule

// ==== logic/micro_exec.sv ====
`timescale 1ns/1ns
`include "uop_cfg.svh"

module micro_exec (
        input  logic            i_clk,
        input  logic            i_reset,
        input  uop_pkg::uop_t   i_uop,
        input  logic            i_uop_valid,
        output logic            o_busy,
        mem_bus_if.requester    bus
);

localparam int NREGS = `UOP_DUMMY1 + 1;

logic [31:0]    regs [NREGS];
logic [31:0]    base_val, next_base, eff_addr;
logic           is_mem;

assign base_val  = regs[i_uop.rn];
assign next_base = base_val + i_uop.imm;
assign eff_addr  = i_uop.pre ? next_base : base_val;

assign is_mem = i_uop_valid &&
                (i_uop.op == uop_pkg::UOP_LDR || i_uop.op == uop_pkg::UOP_STR);

// The sequencer holds the micro-op while busy, so the request stays steady.
assign bus.req   = is_mem;
assign bus.we    = i_uop.op == uop_pkg::UOP_STR;
assign bus.addr  = eff_addr[`UOP_ADDR_W+1:2];      // Byte to word address.
assign bus.wdata = regs[i_uop.rd];

assign o_busy = is_mem && !bus.ack;     // Drops in the ack cycle.

always_ff @(posedge i_clk)
begin
        if (i_reset)
        begin
                for (int i = 0; i < NREGS; i++)
                        regs[i] <= '0;
        end
        else if (i_uop_valid)
        begin
                case (i_uop.op)
                uop_pkg::UOP_MOV_IMM:
                        regs[i_uop.rd] <= i_uop.imm;
                uop_pkg::UOP_MOV_REG:
                        regs[i_uop.rd] <= regs[i_uop.rm];
                uop_pkg::UOP_SUB_IMM:
                        regs[i_uop.rd] <= base_val - i_uop.imm;
                uop_pkg::UOP_LDR, uop_pkg::UOP_STR:
                begin
                        if (bus.ack)
                        begin
                                if (i_uop.wb)
                                        regs[i_uop.rn] <= next_base;
                                // Loaded data wins over a base update to the same register.
                                if (i_uop.op == uop_pkg::UOP_LDR)
                                        regs[i_uop.rd] <= bus.rdata;
                        end
                end
                default:
                        ;
                endcase
        end
end

// A pending request keeps its address until the arbiter and RAM answer.
a_req_held: assert property (@(posedge i_clk) disable iff (i_reset)
        bus.req && !bus.ack |=> bus.req && $stable(bus.addr));

endmodule

// ==== logic/multi_op_sequencer.sv ====
`timescale 1ns/1ns
`include "uop_cfg.svh"

module multi_op_sequencer (
        input  logic            i_clk,
        input  logic            i_reset,
        input  logic [31:0]     i_instr,
        input  logic            i_instr_valid,
        input  logic            i_exec_busy,
        output uop_pkg::uop_t   o_uop,
        output logic            o_uop_valid,
        output logic            o_stall
);

localparam int RW = `UOP_REG_W;
localparam logic [RW-1:0] DUMMY0 = RW'(`UOP_DUMMY0);
localparam logic [RW-1:0] DUMMY1 = RW'(`UOP_DUMMY1);

uop_pkg::seq_state_e    state_q, state_nxt;
logic [15:0]            reglist_q, reglist_nxt;     // Registers still to transfer.

logic [RW-1:0]          rn, rd, rm, low_reg;
logic                   pre_bit, up_bit, wb_bit, load_bit;
logic                   is_block, is_swap, is_mov, is_single;
logic [31:0]            blk_offset, rot_imm, ofs12;
uop_pkg::uop_op_e       mem_op;

function automatic logic [4:0] ones_count(input logic [15:0] list);
        logic [4:0] cnt;
        cnt = '0;
        for (int i = 0; i < 16; i++)
                cnt = cnt + 5'(list[i]);
        return cnt;
endfunction

// Lowest listed register goes first.
function automatic logic [3:0] lowest_bit(input logic [15:0] list);
        logic [3:0] idx;
        idx = '0;
        for (int i = 15; i >= 0; i--)
                if (list[i])
                        idx = 4'(i);
        return idx;
endfunction

function automatic uop_pkg::uop_t mk_uop(input uop_pkg::uop_op_e op,
                                         input logic [RW-1:0] d, input logic [RW-1:0] n,
                                         input logic [RW-1:0] m, input logic [31:0] imm,
                                         input logic pre, input logic wb);
        return '{op, d, n, m, imm, pre, wb};
endfunction

assign rn       = RW'(i_instr[19:16]);
assign rd       = RW'(i_instr[15:12]);
assign rm       = RW'(i_instr[3:0]);
assign pre_bit  = i_instr[24];
assign up_bit   = i_instr[23];
assign wb_bit   = i_instr[21];
assign load_bit = i_instr[20];

assign is_block  = i_instr[27:25] == 3'b100;
assign is_swap   = i_instr[27:23] == 5'b00010 && i_instr[21:20] == 2'b00 &&
                   i_instr[11:4] == 8'h09;
assign is_mov    = i_instr[27:21] == 7'b0011101;   // Immediate MOV.
assign is_single = i_instr[27:25] == 3'b010;       // LDR/STR immediate.

assign blk_offset = {25'd0, ones_count(i_instr[15:0]), 2'b00};
assign rot_imm    = 32'({2{24'd0, i_instr[7:0]}} >> {i_instr[11:8], 1'b0});
assign ofs12      = up_bit ? {20'd0, i_instr[11:0]} : -{20'd0, i_instr[11:0]};
assign mem_op     = load_bit ? uop_pkg::UOP_LDR : uop_pkg::UOP_STR;
assign low_reg    = RW'(lowest_bit(reglist_q));

always_comb
begin
        state_nxt   = state_q;
        reglist_nxt = reglist_q;
        o_uop       = mk_uop(uop_pkg::UOP_NOP, '0, '0, '0, '0, 1'b0, 1'b0);
        o_uop_valid = i_instr_valid;
        o_stall     = 1'b0;

        case (state_q)
        uop_pkg::S_IDLE:
        begin
                if (i_instr_valid && is_block)
                begin
                        // Ascending copies the base, descending starts at the bottom.
                        if (up_bit)
                                o_uop = mk_uop(uop_pkg::UOP_MOV_REG, DUMMY0, '0, rn, '0,
                                               1'b0, 1'b0);
                        else
                                o_uop = mk_uop(uop_pkg::UOP_SUB_IMM, DUMMY0, rn, '0,
                                               blk_offset, 1'b0, 1'b0);
                        reglist_nxt = i_instr[15:0];
                        state_nxt   = uop_pkg::S_MEMOP;
                        o_stall     = 1'b1;
                end
                else if (i_instr_valid && is_swap)
                begin
                        o_uop     = mk_uop(uop_pkg::UOP_LDR, DUMMY1, rn, '0, '0, 1'b1, 1'b0);
                        state_nxt = uop_pkg::S_SWAP1;
                        o_stall   = 1'b1;
                end
                else if (is_mov)
                        o_uop = mk_uop(uop_pkg::UOP_MOV_IMM, rd, '0, '0, rot_imm, 1'b0, 1'b0);
                else if (is_single)
                        o_uop = mk_uop(mem_op, rd, rn, '0, ofs12, pre_bit, wb_bit | ~pre_bit);
        end

        uop_pkg::S_MEMOP:
        begin
                o_uop_valid = 1'b1;
                if (reglist_q != '0)
                begin
                        // IB and DA step before the access, IA and DB after.
                        o_uop = mk_uop(mem_op, low_reg, DUMMY0, '0, 32'd4,
                                       ~(pre_bit ^ up_bit), 1'b1);
                        reglist_nxt = reglist_q & ~(16'd1 << low_reg);
                        o_stall     = 1'b1;
                end
                else
                begin
                        if (wb_bit && up_bit)
                                o_uop = mk_uop(uop_pkg::UOP_MOV_REG, rn, '0, DUMMY0, '0,
                                               1'b0, 1'b0);
                        else if (wb_bit)
                                o_uop = mk_uop(uop_pkg::UOP_SUB_IMM, rn, rn, '0, blk_offset,
                                               1'b0, 1'b0);
                        state_nxt = uop_pkg::S_IDLE;    // Instruction retires here.
                end
        end

        uop_pkg::S_SWAP1:
        begin
                o_uop_valid = 1'b1;
                o_uop       = mk_uop(uop_pkg::UOP_STR, rm, rn, '0, '0, 1'b1, 1'b0);
                state_nxt   = uop_pkg::S_SWAP2;
                o_stall     = 1'b1;
        end

        uop_pkg::S_SWAP2:
        begin
                o_uop_valid = 1'b1;
                o_uop       = mk_uop(uop_pkg::UOP_MOV_REG, rd, '0, DUMMY1, '0, 1'b0, 1'b0);
                state_nxt   = uop_pkg::S_IDLE;
        end
        endcase
end

always_ff @(posedge i_clk)
begin
        if (i_reset)
        begin
                state_q   <= uop_pkg::S_IDLE;
                reglist_q <= '0;
        end
        else if (!i_exec_busy)  // Frozen while a memory access waits.
        begin
                state_q   <= state_nxt;
                reglist_q <= reglist_nxt;
        end
end

// No register ever joins the list once the transfer is running.
a_list_shrinks: assert property (@(posedge i_clk) disable iff (i_reset)
        state_q == uop_pkg::S_MEMOP |=> (reglist_q & ~$past(reglist_q)) == 16'd0);

endmodule

// ==== logic/mem_bus_if.sv ====
`timescale 1ns/1ns
`include "uop_cfg.svh"

interface mem_bus_if;

        logic                   req;
        logic                   we;
        logic [`UOP_ADDR_W-1:0] addr;   // Word address.
        logic [31:0]            wdata;
        logic [31:0]            rdata;  // Valid with ack.
        logic                   ack;

        // Request fields stay steady until ack.
        modport requester (output req, we, addr, wdata, input rdata, ack);
        modport responder (input req, we, addr, wdata, output rdata, ack);

endinterface

// ==== logic/uop_pkg.sv ====
`include "uop_cfg.svh"

package uop_pkg;

        // Micro-op opcodes.
        typedef enum logic [2:0] {
                UOP_NOP,
                UOP_MOV_IMM,    // rd = imm.
                UOP_MOV_REG,    // rd = rm.
                UOP_SUB_IMM,    // rd = rn - imm.
                UOP_LDR,
                UOP_STR
        } uop_op_e;

        // Sequencer states.
        typedef enum logic [1:0] {
                S_IDLE,
                S_MEMOP,
                S_SWAP1,
                S_SWAP2
        } seq_state_e;

        // One micro-op. For a store rd names the data source.
        typedef struct packed {
                uop_op_e                op;
                logic [`UOP_REG_W-1:0]  rd;
                logic [`UOP_REG_W-1:0]  rn;     // Base register.
                logic [`UOP_REG_W-1:0]  rm;
                logic [31:0]            imm;
                logic                   pre;    // Address is rn + imm.
                logic                   wb;     // Base gets rn + imm.
        } uop_t;

endpackage

// ==== logic/uop_cfg.svh ====
`ifndef UOP_CFG_SVH
`define UOP_CFG_SVH

// Register index width, enough for 16 architectural plus 2 hidden registers.
`define UOP_REG_W 5

// Hidden register for the saved or adjusted base of a block transfer.
`define UOP_DUMMY0 16

// Hidden register for the old memory word during a swap.
`define UOP_DUMMY1 17

// Data RAM size in 32-bit words.
`define UOP_RAM_DEPTH 256
`define UOP_ADDR_W 8

`endif
